/* rtl/memPkg.sv */
`default_nettype none

package memPkg;

    // byte address, 64 KiB of RAM
    localparam int unsigned ADDR_W    = 16;
    localparam int unsigned WORD_W    = 32;
    localparam int unsigned BYTE_W    = 8;
    localparam int unsigned RAM_DEPTH = 2 ** ADDR_W;

    // transfer length, code 2'b11 unused
    typedef enum logic [1:0] {
        LEN1 = 2'b00,
        LEN2 = 2'b01,
        LEN4 = 2'b10
    } accessLenE;

    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } dataOpE;

    // who owns the RAM port
    typedef enum logic [1:0] {
        OWN_IDLE  = 2'b00,
        OWN_FETCH = 2'b01,
        OWN_DATA  = 2'b10
    } ownerE;

    // single byte access from a sequencer
    typedef struct packed {
        logic              valid;
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [BYTE_W-1:0] wdata;
    } byteReqT;

    // word level command on the data port
    typedef struct packed {
        dataOpE            op;
        accessLenE         len;
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] wdata;
    } dataCmdT;

endpackage

`default_nettype wire

/* rtl/fetchSeq.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchSeq (
    input  logic                      clk,
    input  logic                      i_arstN,
    input  logic                      i_clr,
    input  logic                      i_hold,
    input  logic                      i_fetchEn,
    input  logic [memPkg::ADDR_W-1:0] i_fetchAddr,
    input  logic                      i_grant,
    input  logic [memPkg::BYTE_W-1:0] i_rdByte,
    output memPkg::byteReqT           o_req,
    output logic                      o_last,
    output logic                      o_fetchDone,
    output logic [memPkg::WORD_W-1:0] o_fetchInst
);

    import memPkg::*;

    logic [2:0]        cntQ;
    logic              doneQ;
    logic [WORD_W-1:0] instQ;
    logic              active;
    logic              step;

    assign active = i_grant && i_fetchEn;
    assign step   = active && !i_hold;

    // stages 0..3 issue reads, stage 4 waits for the last byte
    always_ff @(posedge clk or negedge i_arstN) begin
        if (!i_arstN) begin
            cntQ  <= '0;
            doneQ <= 1'b0;
        end else if (i_clr) begin
            cntQ  <= '0;
            doneQ <= 1'b0;
        end else if (step) begin
            if (doneQ) begin
                doneQ <= 1'b0;
            end else if (cntQ == 3'd4) begin
                cntQ  <= '0;
                doneQ <= 1'b1;
            end else begin
                cntQ <= cntQ + 3'd1;
            end
        end
    end

    // byte k-1 comes back while stage k is active
    always_ff @(posedge clk) begin
        if (step && !doneQ && cntQ != '0) begin
            instQ <= {i_rdByte, instQ[WORD_W-1:BYTE_W]};
        end
    end

    always_comb begin
        o_req       = '0;
        o_req.valid = active && !doneQ && !cntQ[2];
        o_req.addr  = i_fetchAddr + ADDR_W'(cntQ[1:0]);
    end

    assign o_last      = doneQ;
    assign o_fetchDone = doneQ && !i_hold;
    assign o_fetchInst = instQ;

    // the arbiter must drop the grant right after the done cycle
    donePulse: assert property (@(posedge clk) disable iff (!i_arstN)
        o_fetchDone |=> !o_fetchDone);

endmodule

`default_nettype wire

/* rtl/dataSeq.sv */
`timescale 1ns/1ps
`default_nettype none

module dataSeq (
    input  logic                      clk,
    input  logic                      i_arstN,
    input  logic                      i_clr,
    input  logic                      i_hold,
    input  logic                      i_dataEn,
    input  memPkg::dataCmdT           i_dataCmd,
    input  logic                      i_grant,
    input  logic [memPkg::BYTE_W-1:0] i_rdByte,
    output memPkg::byteReqT           o_req,
    output logic                      o_last,
    output logic                      o_dataDone,
    output logic [memPkg::WORD_W-1:0] o_dataRdata
);

    import memPkg::*;

    typedef enum logic [2:0] {
        ST_B0   = 3'd0,
        ST_B1   = 3'd1,
        ST_B2   = 3'd2,
        ST_B3   = 3'd3,
        ST_TAIL = 3'd4,
        ST_DONE = 3'd5
    } stageE;

    stageE             stageQ;
    dataCmdT           cmdQ;
    dataCmdT           cmd;
    logic [1:0]        byteIdx;
    logic [1:0]        lastIdx;
    logic              pendQ;
    logic [1:0]        pendIdxQ;
    logic [WORD_W-1:0] rdQ;
    logic              active;
    logic              step;
    logic              issuing;

    function automatic logic [1:0] lastIdxOf(accessLenE len);
        case (len)
            LEN1:    return 2'd0;
            LEN2:    return 2'd1;
            default: return 2'd3;
        endcase
    endfunction

    assign active  = i_grant && i_dataEn;
    assign step    = active && !i_hold;
    // first granted cycle works straight from the port
    assign cmd     = (stageQ == ST_B0) ? i_dataCmd : cmdQ;
    assign byteIdx = stageQ[1:0];
    assign lastIdx = lastIdxOf(cmd.len);
    assign issuing = active && !stageQ[2];

    always_ff @(posedge clk or negedge i_arstN) begin
        if (!i_arstN) begin
            stageQ <= ST_B0;
            pendQ  <= 1'b0;
        end else if (i_clr) begin
            stageQ <= ST_B0;
            pendQ  <= 1'b0;
        end else if (step) begin
            pendQ <= issuing && (cmd.op == OP_LOAD);
            case (stageQ)
                ST_B0, ST_B1, ST_B2, ST_B3: begin
                    if (byteIdx != lastIdx) begin
                        stageQ <= stageE'(stageQ + 3'd1);
                    end else if (cmd.op == OP_STORE) begin
                        stageQ <= ST_DONE;
                    end else begin
                        // loads wait one more cycle for the last byte
                        stageQ <= ST_TAIL;
                    end
                end
                ST_TAIL: begin
                    stageQ <= ST_DONE;
                end
                default: begin
                    stageQ <= ST_B0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (step && stageQ == ST_B0) begin
            cmdQ <= i_dataCmd;
        end
        if (step) begin
            pendIdxQ <= byteIdx;
            if (stageQ == ST_B0) begin
                rdQ <= '0;
            end else if (pendQ) begin
                rdQ[pendIdxQ*BYTE_W +: BYTE_W] <= i_rdByte;
            end
        end
    end

    always_comb begin
        o_req       = '0;
        o_req.valid = issuing;
        o_req.write = issuing && (cmd.op == OP_STORE);
        o_req.addr  = cmd.addr + ADDR_W'(byteIdx);
        o_req.wdata = cmd.wdata[byteIdx*BYTE_W +: BYTE_W];
    end

    assign o_last      = (stageQ == ST_DONE);
    assign o_dataDone  = (stageQ == ST_DONE) && !i_hold;
    assign o_dataRdata = rdQ;

    // latched command and the requester's held command must agree on length
    writeInLen: assert property (@(posedge clk) disable iff (!i_arstN)
        o_req.valid && o_req.write |-> byteIdx <= lastIdxOf(i_dataCmd.len));

endmodule

`default_nettype wire

/* rtl/busArbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module busArbiter (
    input  logic                      clk,
    input  logic                      i_arstN,
    input  logic                      i_clr,
    input  logic                      i_hold,
    input  logic                      i_fetchEn,
    input  logic                      i_dataEn,
    input  memPkg::byteReqT           i_fetchReq,
    input  memPkg::byteReqT           i_dataReq,
    input  logic                      i_fetchLast,
    input  logic                      i_dataLast,
    input  logic [memPkg::BYTE_W-1:0] i_ramRdByte,
    output logic                      o_fetchGrant,
    output logic                      o_dataGrant,
    output memPkg::byteReqT           o_ramReq,
    output logic [memPkg::BYTE_W-1:0] o_rdByte
);

    import memPkg::*;

    ownerE   ownerQ;
    byteReqT sel;

    // data side wins when both ask at idle
    always_ff @(posedge clk or negedge i_arstN) begin
        if (!i_arstN) begin
            ownerQ <= OWN_IDLE;
        end else if (i_clr) begin
            ownerQ <= OWN_IDLE;
        end else if (!i_hold) begin
            case (ownerQ)
                OWN_IDLE: begin
                    if (i_dataEn) begin
                        ownerQ <= OWN_DATA;
                    end else if (i_fetchEn) begin
                        ownerQ <= OWN_FETCH;
                    end
                end
                OWN_FETCH: begin
                    if (i_fetchLast) begin
                        ownerQ <= OWN_IDLE;
                    end
                end
                OWN_DATA: begin
                    if (i_dataLast) begin
                        ownerQ <= OWN_IDLE;
                    end
                end
                default: begin
                    ownerQ <= OWN_IDLE;
                end
            endcase
        end
    end

    assign o_fetchGrant = (ownerQ == OWN_FETCH);
    assign o_dataGrant  = (ownerQ == OWN_DATA);

    always_comb begin
        case (ownerQ)
            OWN_FETCH: sel = i_fetchReq;
            OWN_DATA:  sel = i_dataReq;
            default:   sel = '0;
        endcase
        o_ramReq       = sel;
        // RAM must not change while the core is stalled
        o_ramReq.write = sel.write && !i_hold;
    end

    // both sequencers see every read byte, only the owner uses it
    assign o_rdByte = i_ramRdByte;

    // a sequencer drives the port only while it holds the grant
    reqNeedsGrant: assert property (@(posedge clk) disable iff (!i_arstN)
        (!i_fetchReq.valid || o_fetchGrant) && (!i_dataReq.valid || o_dataGrant));

    // a write held back by the stall is still pending next cycle
    heldWriteKept: assert property (@(posedge clk) disable iff (!i_arstN)
        sel.valid && sel.write && i_hold && !i_clr
        |=> sel.valid && sel.write && $stable(sel.addr));

endmodule

`default_nettype wire

/* rtl/byteRam.sv */
`timescale 1ns/1ps
`default_nettype none

module byteRam (
    input  logic                      clk,
    input  logic                      i_hold,
    input  memPkg::byteReqT           i_req,
    output logic [memPkg::BYTE_W-1:0] o_rdByte
);

    import memPkg::*;

    logic [BYTE_W-1:0] mem [RAM_DEPTH];
    logic [BYTE_W-1:0] rdQ;

    always_ff @(posedge clk) begin
        if (i_req.valid && i_req.write) begin
            mem[i_req.addr] <= i_req.wdata;
        end
    end

    // read latency one, frozen during hold
    always_ff @(posedge clk) begin
        if (!i_hold) begin
            rdQ <= mem[i_req.addr];
        end
    end

    assign o_rdByte = rdQ;

endmodule

`default_nettype wire

/* rtl/memSubsys.sv */
`timescale 1ns/1ps
`default_nettype none

module memSubsys (
    input  logic                      clk,
    input  logic                      i_arstN,
    input  logic                      i_fetchEn,
    input  logic [memPkg::ADDR_W-1:0] i_fetchAddr,
    output logic                      o_fetchDone,
    output logic [memPkg::WORD_W-1:0] o_fetchInst,
    input  logic                      i_dataEn,
    input  memPkg::dataCmdT           i_dataCmd,
    output logic                      o_dataDone,
    output logic [memPkg::WORD_W-1:0] o_dataRdata,
    input  logic                      i_ioFull,
    input  logic                      i_clr
);

    import memPkg::*;

    byteReqT           fetchReq;
    byteReqT           dataReq;
    byteReqT           ramReq;
    logic              fetchLast;
    logic              dataLast;
    logic              fetchGrant;
    logic              dataGrant;
    logic [BYTE_W-1:0] ramRdByte;
    logic [BYTE_W-1:0] rdByte;

    fetchSeq fetchSeq_inst (
        .clk         (clk),
        .i_arstN     (i_arstN),
        .i_clr       (i_clr),
        .i_hold      (i_ioFull),
        .i_fetchEn   (i_fetchEn),
        .i_fetchAddr (i_fetchAddr),
        .i_grant     (fetchGrant),
        .i_rdByte    (rdByte),
        .o_req       (fetchReq),
        .o_last      (fetchLast),
        .o_fetchDone (o_fetchDone),
        .o_fetchInst (o_fetchInst)
    );

    dataSeq dataSeq_inst (
        .clk         (clk),
        .i_arstN     (i_arstN),
        .i_clr       (i_clr),
        .i_hold      (i_ioFull),
        .i_dataEn    (i_dataEn),
        .i_dataCmd   (i_dataCmd),
        .i_grant     (dataGrant),
        .i_rdByte    (rdByte),
        .o_req       (dataReq),
        .o_last      (dataLast),
        .o_dataDone  (o_dataDone),
        .o_dataRdata (o_dataRdata)
    );

    busArbiter busArbiter_inst (
        .clk          (clk),
        .i_arstN      (i_arstN),
        .i_clr        (i_clr),
        .i_hold       (i_ioFull),
        .i_fetchEn    (i_fetchEn),
        .i_dataEn     (i_dataEn),
        .i_fetchReq   (fetchReq),
        .i_dataReq    (dataReq),
        .i_fetchLast  (fetchLast),
        .i_dataLast   (dataLast),
        .i_ramRdByte  (ramRdByte),
        .o_fetchGrant (fetchGrant),
        .o_dataGrant  (dataGrant),
        .o_ramReq     (ramReq),
        .o_rdByte     (rdByte)
    );

    byteRam byteRam_inst (
        .clk      (clk),
        .i_hold   (i_ioFull),
        .i_req    (ramReq),
        .o_rdByte (ramRdByte)
    );

endmodule

`default_nettype wire

/* verif/memSubsysTb.sv */
`timescale 1ns/1ps
`default_nettype none

module memSubsysTb;

    import memPkg::*;

    localparam int TIMEOUT = 100;

    logic              clk;
    logic              i_arstN;
    logic              i_fetchEn;
    logic [ADDR_W-1:0] i_fetchAddr;
    logic              o_fetchDone;
    logic [WORD_W-1:0] o_fetchInst;
    logic              i_dataEn;
    dataCmdT           i_dataCmd;
    logic              o_dataDone;
    logic [WORD_W-1:0] o_dataRdata;
    logic              i_ioFull;
    logic              i_clr;

    integer            seed;
    int                errCount;
    int                checkCount;
    bit                holdOn;
    bit                latCheck;
    int                holdLeft;
    time               dataDoneT;
    time               fetchDoneT;
    logic [BYTE_W-1:0] model [bit [ADDR_W-1:0]];
    logic [ADDR_W-1:0] stAddr [$];
    int                stBytes [$];
    logic [ADDR_W-1:0] wordAddr [$];

    memSubsys memSubsys_inst (
        .clk         (clk),
        .i_arstN     (i_arstN),
        .i_fetchEn   (i_fetchEn),
        .i_fetchAddr (i_fetchAddr),
        .o_fetchDone (o_fetchDone),
        .o_fetchInst (o_fetchInst),
        .i_dataEn    (i_dataEn),
        .i_dataCmd   (i_dataCmd),
        .o_dataDone  (o_dataDone),
        .o_dataRdata (o_dataRdata),
        .i_ioFull    (i_ioFull),
        .i_clr       (i_clr)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int lenBytes(accessLenE len);
        case (len)
            LEN1:    return 1;
            LEN2:    return 2;
            default: return 4;
        endcase
    endfunction

    function automatic accessLenE randLen();
        int r;
        r = $unsigned($random(seed)) % 3;
        return (r == 0) ? LEN1 : (r == 1) ? LEN2 : LEN4;
    endfunction

    // little endian word from the model, zero extended
    function automatic logic [WORD_W-1:0] modelWord(logic [ADDR_W-1:0] addr, int n);
        logic [WORD_W-1:0] w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            w[i*BYTE_W +: BYTE_W] = model[addr + ADDR_W'(i)];
        end
        return w;
    endfunction

    task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            $display("FAIL at %0t: %s = %h, expected %h", $time, name, got, exp);
            errCount++;
        end
    endtask

    // random stall stretches of one to four cycles
    task automatic updateHold();
        if (!holdOn) begin
            i_ioFull = 1'b0;
        end else if (holdLeft > 0) begin
            i_ioFull = 1'b1;
            holdLeft--;
        end else if (($random(seed) & 3) == 0) begin
            i_ioFull = 1'b1;
            holdLeft = $unsigned($random(seed)) % 4;
        end else begin
            i_ioFull = 1'b0;
        end
    endtask

    task automatic waitDone(input bit isData, output bit ok, output int cycles,
                            output logic [WORD_W-1:0] result);
        ok     = 1'b0;
        cycles = 0;
        result = '0;
        while (!ok && cycles < TIMEOUT) begin
            @(posedge clk);
            if (isData && o_dataDone === 1'b1) begin
                ok        = 1'b1;
                result    = o_dataRdata;
                dataDoneT = $time;
            end else if (!isData && o_fetchDone === 1'b1) begin
                ok         = 1'b1;
                result     = o_fetchInst;
                fetchDoneT = $time;
            end else begin
                cycles++;
                @(negedge clk);
                updateHold();
            end
        end
        if (!ok) begin
            $display("ERROR at %0t: no %s done pulse within %0d cycles", $time,
                     isData ? "data" : "fetch", TIMEOUT);
            errCount++;
        end
    endtask

    task automatic runFetch(input logic [ADDR_W-1:0] addr);
        bit                ok;
        int                cycles;
        logic [WORD_W-1:0] inst;
        @(negedge clk);
        i_fetchAddr = addr;
        i_fetchEn   = 1'b1;
        waitDone(1'b0, ok, cycles, inst);
        @(negedge clk);
        i_fetchEn = 1'b0;
        i_ioFull  = 1'b0;
        holdLeft  = 0;
        if (ok) begin
            checkVal("o_fetchInst", inst, modelWord(addr, 4));
            if (latCheck) begin
                checkVal("fetch latency", cycles, 6);
            end
        end
    endtask

    task automatic runData(input dataOpE op, input accessLenE len,
                           input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] wdata);
        bit                ok;
        int                cycles;
        int                n;
        logic [WORD_W-1:0] rdata;
        n = lenBytes(len);
        @(negedge clk);
        i_dataCmd.op    = op;
        i_dataCmd.len   = len;
        i_dataCmd.addr  = addr;
        i_dataCmd.wdata = wdata;
        i_dataEn        = 1'b1;
        waitDone(1'b1, ok, cycles, rdata);
        @(negedge clk);
        i_dataEn = 1'b0;
        i_ioFull = 1'b0;
        holdLeft = 0;
        if (ok && op == OP_STORE) begin
            // lowest byte goes to the lowest address
            for (int i = 0; i < n; i++) begin
                model[addr + ADDR_W'(i)] = wdata[i*BYTE_W +: BYTE_W];
            end
            stAddr.push_back(addr);
            stBytes.push_back(n);
            if (n == 4) begin
                wordAddr.push_back(addr);
            end
            if (latCheck) begin
                checkVal("store latency", cycles, n + 1);
            end
        end else if (ok) begin
            checkVal("o_dataRdata", rdata, modelWord(addr, n));
            if (latCheck) begin
                checkVal("load latency", cycles, n + 2);
            end
        end
    endtask

    task automatic randomStore(input bit wordOnly);
        accessLenE         len;
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] data;
        len  = wordOnly ? LEN4 : randLen();
        addr = ADDR_W'($random(seed));
        data = $random(seed);
        runData(OP_STORE, len, addr, data);
    endtask

    // only bytes covered by an earlier store are read back
    task automatic randomLoad();
        int        idx;
        accessLenE len;
        idx = $unsigned($random(seed)) % stAddr.size();
        len = randLen();
        if (lenBytes(len) > stBytes[idx]) begin
            len = (stBytes[idx] == 1) ? LEN1 : LEN2;
        end
        runData(OP_LOAD, len, stAddr[idx], '0);
    endtask

    task automatic randomFetch();
        int idx;
        idx = $unsigned($random(seed)) % wordAddr.size();
        runFetch(wordAddr[idx]);
    endtask

    task automatic priorityPair();
        int                idx;
        logic [ADDR_W-1:0] fAddr;
        idx        = $unsigned($random(seed)) % wordAddr.size();
        fAddr      = wordAddr[idx];
        dataDoneT  = 0;
        fetchDoneT = 0;
        fork
            randomLoad();
            runFetch(fAddr);
        join
        checkVal("o_dataDone before o_fetchDone", dataDoneT < fetchDoneT, 1'b1);
    endtask

    task automatic clearDuringLoad();
        int                idx;
        int                k;
        int                cycles;
        bit                seen;
        bit                ok;
        logic [WORD_W-1:0] rdata;
        idx = $unsigned($random(seed)) % wordAddr.size();
        k   = 2 + $unsigned($random(seed)) % 3;
        @(negedge clk);
        i_dataCmd.op    = OP_LOAD;
        i_dataCmd.len   = LEN4;
        i_dataCmd.addr  = wordAddr[idx];
        i_dataCmd.wdata = '0;
        i_dataEn        = 1'b1;
        repeat (k) @(negedge clk);
        i_clr = 1'b1;
        @(negedge clk);
        i_clr  = 1'b0;
        // enable stays high, so the load starts over from idle
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < 6) begin
            @(posedge clk);
            seen = (o_dataDone === 1'b1);
            cycles++;
        end
        if (seen) begin
            $display("ERROR at %0t: o_dataDone raised for a cleared load", $time);
            errCount++;
        end
        waitDone(1'b1, ok, cycles, rdata);
        @(negedge clk);
        i_dataEn = 1'b0;
        if (ok) begin
            checkVal("o_dataRdata", rdata, modelWord(wordAddr[idx], 4));
        end
    endtask

    // no done pulse while stalled
    always @(posedge clk) begin
        if (i_arstN === 1'b1 && i_ioFull === 1'b1) begin
            checkVal("o_fetchDone", o_fetchDone, 1'b0);
            checkVal("o_dataDone", o_dataDone, 1'b0);
        end
    end

    initial begin
        seed        = 32'he451;
        errCount    = 0;
        checkCount  = 0;
        holdOn      = 1'b0;
        latCheck    = 1'b1;
        holdLeft    = 0;
        i_arstN     = 1'b0;
        i_fetchEn   = 1'b0;
        i_fetchAddr = '0;
        i_dataEn    = 1'b0;
        i_dataCmd   = '0;
        i_ioFull    = 1'b0;
        i_clr       = 1'b0;
        @(posedge clk);
        repeat (3) begin
            @(posedge clk);
            checkVal("o_fetchDone", o_fetchDone, 1'b0);
            checkVal("o_dataDone", o_dataDone, 1'b0);
        end
        @(negedge clk);
        i_arstN = 1'b1;
        repeat (2) begin
            @(posedge clk);
            checkVal("o_fetchDone", o_fetchDone, 1'b0);
            checkVal("o_dataDone", o_dataDone, 1'b0);
        end
        repeat (4) randomStore(1'b1);
        repeat (30) randomStore(1'b0);
        repeat (40) randomLoad();
        repeat (20) randomFetch();
        latCheck = 1'b0;
        repeat (10) priorityPair();
        holdOn = 1'b1;
        repeat (40) begin
            case ($unsigned($random(seed)) % 3)
                0:       randomStore(1'b0);
                1:       randomLoad();
                default: randomFetch();
            endcase
        end
        holdOn   = 1'b0;
        latCheck = 1'b1;
        clearDuringLoad();
        randomStore(1'b1);
        runData(OP_LOAD, LEN4, wordAddr[$], '0);
        runFetch(wordAddr[$]);
        $display("memSubsysTb: %0d checks, %0d errors", checkCount, errCount);
        if (errCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* memSubsys.f */
rtl/memPkg.sv
rtl/fetchSeq.sv
rtl/dataSeq.sv
rtl/busArbiter.sv
rtl/byteRam.sv
rtl/memSubsys.sv
verif/memSubsysTb.sv

/* Bender.yml */
package:
  name: memSubsys

sources:
  # design, package first
  - files:
      - rtl/memPkg.sv
      - rtl/fetchSeq.sv
      - rtl/dataSeq.sv
      - rtl/busArbiter.sv
      - rtl/byteRam.sv
      - rtl/memSubsys.sv

  # testbench
  - target: simulation
    files:
      - verif/memSubsysTb.sv
